/* compile.f */
hw/cpu_pkg.sv
hw/ex_count_bit.sv
hw/ex_multi_cyc.sv
hw/cpu_ex.sv
hw/ex_commit.sv
hw/cp0_regs.sv
hw/cpu_ex_unit.sv
sim/cpu_ex_unit_chk.sv
sim/tb_cpu_ex_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cpu_ex_unit -f compile.f -o sim_tb_cpu_ex_unit
./obj_dir/sim_tb_cpu_ex_unit 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "simulation ended without passing"
	exit 1
fi

/* sim/tb_cpu_ex_unit.sv */
`timescale 1ns/10ps

module tb_cpu_ex_unit;

import cpu_pkg::*;

logic         clk;
logic         rst;
bit_t         flush;
oper_t        op;
word_t        pc;
word_t        inst;
word_t        reg1;
word_t        reg2;
word_t        imm;
bit_t         reg_we;
reg_addr_t    reg_waddr;
bit_t         stall_req;
bit_t         mem_reg_we;
reg_addr_t    mem_reg_waddr;
word_t        mem_reg_wdata;
bit_t         mem_mem_ce;
bit_t         mem_mem_we;
word_t        mem_mem_addr;
logic [3:0]   mem_mem_sel;
word_t        mem_mem_wdata;
bit_t         mem_cp0_we;
reg_addr_t    mem_cp0_waddr;
cp0_sel_t     mem_cp0_sel;
word_t        mem_cp0_wdata;
bit_t         mem_hilo_we;
double_word_t mem_hilo;
except_t      mem_except;

int           seed;
int           last_stall;
double_word_t exp_hilo;
word_t        cp0_model [32];

oper_t alu_ops [21] = '{op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav, op_and, op_or,
	op_xor, op_nor, op_lui, op_addu, op_subu, op_slt, op_sltu, op_clz, op_clo, op_jal,
	op_jalr, op_add, op_sub};
oper_t mem_ops [8] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw};
oper_t multi_ops [4] = '{op_mult, op_multu, op_div, op_divu};
oper_t trap_ops [4] = '{op_syscall, op_break, op_eret, op_invalid};
reg_addr_t cp0_list [4] = '{cp0_status_addr, cp0_cause_addr, cp0_epc_addr, cp0_badvaddr_addr};

cpu_ex_unit i_cpu_ex_unit(.*);

always #5 clk = ~clk;

function automatic word_t leading_count(input word_t v, input bit_t b);
	word_t n;
	bit_t  run;
	n = '0;
	run = 1'b1;
	for (int i = 31; i >= 0; i--)
	begin
		if (run && v[i] == b)
		begin
			n = n + 32'd1;
		end
		else
		begin
			run = 1'b0;
		end
	end
	return n;
endfunction

function automatic word_t alu_result(input oper_t o, input word_t p, input word_t in,
	input word_t a, input word_t b, input word_t im);
	case (o)
		op_sll: return b << in[10:6];
		op_srl: return b >> in[10:6];
		op_sra: return word_t'($signed(b) >>> in[10:6]);
		op_sllv: return b << a[4:0];
		op_srlv: return b >> a[4:0];
		op_srav: return word_t'($signed(b) >>> a[4:0]);
		op_and: return a & b;
		op_or: return a | b;
		op_xor: return a ^ b;
		op_nor: return ~(a | b);
		op_lui: return {im[15:0], 16'h0000};
		op_add, op_addu: return a + b;
		op_sub, op_subu: return a - b;
		op_slt: return {31'b0, $signed(a) < $signed(b)};
		op_sltu: return {31'b0, a < b};
		op_clz: return leading_count(a, 1'b0);
		op_clo: return leading_count(a, 1'b1);
		op_jal, op_jalr: return p + 32'd8;
		default: return '0;
	endcase
endfunction

// 33 bit signed result, overflow when the two top bits differ
function automatic bit_t add_overflow(input oper_t o, input word_t a, input word_t b);
	logic signed [32:0] wide;
	wide = '0;
	if (o == op_add)
	begin
		wide = $signed({a[31], a}) + $signed({b[31], b});
	end
	else if (o == op_sub)
	begin
		wide = $signed({a[31], a}) - $signed({b[31], b});
	end
	return wide[32] != wide[31];
endfunction

function automatic word_t expected_mask(input reg_addr_t addr);
	case (addr)
		cp0_status_addr: return 32'h0000_ff03;
		cp0_cause_addr: return 32'h0000_0300;
		cp0_epc_addr, cp0_count_addr: return 32'hffff_ffff;
		default: return 32'h0000_0000;
	endcase
endfunction

function automatic double_word_t product_model(input bit_t sgn, input word_t a, input word_t b);
	longint sa;
	longint sb;
	if (sgn)
	begin
		sa = longint'($signed(a));
		sb = longint'($signed(b));
	end
	else
	begin
		sa = longint'({32'h0, a});
		sb = longint'({32'h0, b});
	end
	return double_word_t'(sa * sb);
endfunction

// remainder in the upper word, quotient in the lower
function automatic double_word_t quotient_model(input bit_t sgn, input word_t a, input word_t b);
	word_t q;
	word_t r;
	if (b == '0)
	begin
		q = 32'hffff_ffff;
		r = a;
	end
	else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff)
	begin
		q = a;
		r = '0;
	end
	else if (sgn)
	begin
		q = word_t'($signed(a) / $signed(b));
		r = word_t'($signed(a) % $signed(b));
	end
	else
	begin
		q = a / b;
		r = a % b;
	end
	return {r, q};
endfunction

task automatic expect_value(input string what, input logic [63:0] got, input logic [63:0] exp);
	assert (got === exp)
	else
	begin
		$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		$display("Testbench failed");
		$fatal(1);
	end
endtask

// returns at the falling edge where the latched result is on the mem_ outputs
task automatic issue(input oper_t o, input word_t p, input word_t in, input word_t a,
	input word_t b, input word_t im, input bit_t we, input reg_addr_t wa);
	int waited;
	op = o;
	pc = p;
	inst = in;
	reg1 = a;
	reg2 = b;
	imm = im;
	reg_we = we;
	reg_waddr = wa;
	waited = 0;
	#1;
	while (stall_req)
	begin
		@(negedge clk);
		waited++;
		if (waited >= 100)
		begin
			$display("Timeout: stall_req stayed high for 100 cycles at %0t ns", $time);
			$display("Testbench failed");
			$fatal(1);
		end
	end
	last_stall = waited;
	@(negedge clk);
endtask

task automatic read_hilo_and_check();
	issue(op_mfhi, '0, '0, '0, '0, '0, 1'b1, 5'd3);
	expect_value("mfhi result", 64'(mem_reg_wdata), 64'(exp_hilo[63:32]));
	issue(op_mflo, '0, '0, '0, '0, '0, 1'b1, 5'd3);
	expect_value("mflo result", 64'(mem_reg_wdata), 64'(exp_hilo[31:0]));
endtask

task automatic idle_cycles(input int n);
	for (int k = 0; k < n; k++)
	begin
		issue(op_sll, '0, '0, '0, '0, '0, 1'b0, 5'd0);
	end
endtask

initial
begin
	int           i;
	oper_t        o;
	word_t        a;
	word_t        b;
	word_t        im;
	word_t        p;
	word_t        in;
	word_t        addr;
	word_t        c1;
	logic [3:0]   sel;
	word_t        wdata;
	bit_t         st;
	bit_t         unal;
	double_word_t hl;
	except_t      e;
	reg_addr_t    ra;

	seed = 32'h8408;
	clk = 1'b0;
	rst = 1'b1;
	flush = 1'b0;
	op = op_sll;
	pc = '0;
	inst = '0;
	reg1 = '0;
	reg2 = '0;
	imm = '0;
	reg_we = 1'b0;
	reg_waddr = '0;
	exp_hilo = '0;
	last_stall = 0;
	for (i = 0; i < 32; i++)
	begin
		cp0_model[i] = '0;
	end
	repeat (10) @(negedge clk);
	rst = 1'b0;
	expect_value("enables after reset", 64'({mem_reg_we, mem_hilo_we, mem_cp0_we, mem_mem_ce,
		mem_mem_we, mem_except, stall_req}), 64'(0));

	// alu, shifts, clz/clo, link
	for (i = 0; i < 63; i++)
	begin
		o = alu_ops[i % 21];
		a = $random(seed) >> (i % 33);
		if (o == op_clo)
		begin
			a = ~a;
		end
		b = $random(seed);
		im = $random(seed);
		p = $random(seed) & 32'hffff_fffc;
		in = $random(seed);
		issue(o, p, in, a, b, im, 1'b1, reg_addr_t'(i));
		expect_value("reg result", 64'(mem_reg_wdata), 64'(alu_result(o, p, in, a, b, im)));
		expect_value("reg_we", 64'(mem_reg_we), 64'(1));
		expect_value("reg_waddr", 64'(mem_reg_waddr), 64'(reg_addr_t'(i)));
		expect_value("overflow", 64'(mem_except[except_overflow]), 64'(add_overflow(o, a, b)));
	end
	issue(op_add, '0, '0, 32'h7fff_ffff, 32'h1, '0, 1'b1, 5'd1);
	expect_value("add overflow", 64'(mem_except[except_overflow]), 64'(1));
	issue(op_sub, '0, '0, 32'h8000_0000, 32'h1, '0, 1'b1, 5'd1);
	expect_value("sub overflow", 64'(mem_except[except_overflow]), 64'(1));

	// loads and stores
	for (i = 0; i < 40; i++)
	begin
		o = mem_ops[i % 8];
		a = $random(seed);
		b = $random(seed);
		im = word_t'($random(seed)) & 32'h0000_00ff;
		addr = a + im;
		st = (o == op_sb) || (o == op_sh) || (o == op_sw);
		case (o)
			op_lw, op_sw:
			begin
				sel = 4'b1111;
				wdata = b;
				unal = (addr[1:0] != 2'b00);
			end
			op_lh, op_lhu, op_sh:
			begin
				sel = addr[1] ? 4'b1100 : 4'b0011;
				wdata = addr[1] ? (b << 16) : b;
				unal = addr[0];
			end
			default:
			begin
				sel = 4'b0001 << addr[1:0];
				wdata = b << (8 * addr[1:0]);
				unal = 1'b0;
			end
		endcase
		issue(o, '0, '0, a, b, im, !st, 5'd2);
		expect_value("mem_ce", 64'(mem_mem_ce), 64'(1));
		expect_value("mem_we", 64'(mem_mem_we), 64'(st));
		expect_value("mem_addr", 64'(mem_mem_addr), 64'(addr));
		expect_value("mem_sel", 64'(mem_mem_sel), 64'(sel));
		if (st)
		begin
			expect_value("store data", 64'(mem_mem_wdata), 64'(wdata));
		end
		expect_value("unaligned", 64'(mem_except[except_daddr_unaligned]), 64'(unal));
	end

	// hi/lo writes read back through forwarding, then from the register
	a = $random(seed);
	b = $random(seed);
	issue(op_mthi, '0, '0, a, '0, '0, 1'b0, 5'd0);
	expect_value("mthi we", 64'(mem_hilo_we), 64'(1));
	issue(op_mtlo, '0, '0, b, '0, '0, 1'b0, 5'd0);
	expect_value("mtlo hilo", 64'(mem_hilo), 64'({a, b}));
	exp_hilo = {a, b};
	read_hilo_and_check();
	idle_cycles(3);
	read_hilo_and_check();

	// multiply and divide, the last round divides by zero
	for (i = 0; i < 12; i++)
	begin
		o = multi_ops[i % 4];
		a = $random(seed);
		b = $random(seed);
		if (i >= 8)
		begin
			a = a | 32'h8000_0000;
			b = '0;
		end
		issue(o, '0, '0, a, b, '0, 1'b0, 5'd0);
		if (o == op_mult || o == op_multu)
		begin
			hl = product_model(o == op_mult, a, b);
			expect_value("mult stall cycles", 64'(last_stall), 64'(1));
		end
		else
		begin
			hl = quotient_model(o == op_div, a, b);
			expect_value("div stall cycles", 64'(last_stall), 64'(div_cycles + 1));
		end
		expect_value("multi hilo_we", 64'(mem_hilo_we), 64'(1));
		expect_value("multi hilo", 64'(mem_hilo), 64'(hl));
		exp_hilo = hl;
		read_hilo_and_check();
	end
	a = $random(seed);
	b = $random(seed);
	issue(op_mul, '0, '0, a, b, '0, 1'b1, 5'd5);
	hl = product_model(1'b1, a, b);
	expect_value("mul result", 64'(mem_reg_wdata), 64'(hl[31:0]));
	expect_value("mul hilo_we", 64'(mem_hilo_we), 64'(0));

	// cp0 write then immediate read
	for (i = 0; i < 4; i++)
	begin
		ra = cp0_list[i];
		b = $random(seed);
		in = {16'h0, ra, 11'h0};
		issue(op_mtc0, '0, in, '0, b, '0, 1'b0, 5'd0);
		expect_value("cp0_we", 64'(mem_cp0_we), 64'(1));
		expect_value("cp0_waddr", 64'(mem_cp0_waddr), 64'(ra));
		expect_value("cp0_sel", 64'(mem_cp0_sel), 64'(0));
		expect_value("cp0_wdata", 64'(mem_cp0_wdata), 64'(b));
		expect_value("mtc0 priv", 64'(mem_except[except_priv_inst]), 64'(1));
		cp0_model[ra] = (expected_mask(ra) & b) | (~expected_mask(ra) & cp0_model[ra]);
		issue(op_mfc0, '0, in, '0, '0, '0, 1'b1, 5'd8);
		expect_value("mfc0 forwarded", 64'(mem_reg_wdata), 64'(cp0_model[ra]));
	end
	idle_cycles(2);
	for (i = 0; i < 4; i++)
	begin
		ra = cp0_list[i];
		issue(op_mfc0, '0, {16'h0, ra, 11'h0}, '0, '0, '0, 1'b1, 5'd8);
		expect_value("mfc0 committed", 64'(mem_reg_wdata), 64'(cp0_model[ra]));
	end
	issue(op_mfc0, '0, {16'h0, cp0_count_addr, 11'h0}, '0, '0, '0, 1'b1, 5'd8);
	c1 = mem_reg_wdata;
	idle_cycles(1);
	issue(op_mfc0, '0, {16'h0, cp0_count_addr, 11'h0}, '0, '0, '0, 1'b1, 5'd8);
	expect_value("count changed", 64'(c1 != mem_reg_wdata), 64'(1));

	for (i = 0; i < 4; i++)
	begin
		o = trap_ops[i];
		issue(o, '0, '0, '0, '0, '0, 1'b0, 5'd0);
		e = '0;
		case (o)
			op_syscall: e[except_syscall] = 1'b1;
			op_break: e[except_break] = 1'b1;
			op_eret:
			begin
				e[except_eret] = 1'b1;
				e[except_priv_inst] = 1'b1;
			end
			default: e[except_invalid_inst] = 1'b1;
		endcase
		expect_value("exception flags", 64'(mem_except), 64'(e));
	end

	// flush in the middle of a divide
	op = op_div;
	reg1 = $random(seed);
	reg2 = $random(seed);
	reg_we = 1'b0;
	repeat (5) @(negedge clk);
	expect_value("stall during divide", 64'(stall_req), 64'(1));
	flush = 1'b1;
	@(negedge clk);
	// next instruction arrives while flush is still high
	op = op_mthi;
	reg1 = $random(seed);
	#1;
	expect_value("stall after flush", 64'(stall_req), 64'(0));
	@(negedge clk);
	expect_value("hilo_we after flush", 64'(mem_hilo_we), 64'(0));
	flush = 1'b0;
	read_hilo_and_check();

	$display("Testbench passed");
	$finish;
end

endmodule

/* sim/cpu_ex_unit_chk.sv */
`timescale 1ns/10ps

module cpu_ex_unit_chk(
	input logic             clk,
	input logic             rst,
	input cpu_pkg::bit_t    stall_req,
	input cpu_pkg::bit_t    mem_reg_we,
	input cpu_pkg::bit_t    mem_hilo_we,
	input cpu_pkg::bit_t    mem_cp0_we,
	input cpu_pkg::bit_t    mem_mem_ce,
	input cpu_pkg::bit_t    mem_mem_we,
	input cpu_pkg::except_t mem_except
);

import cpu_pkg::*;

int stall_len;

// length of the current stall run
always_ff @(posedge clk)
begin
	if (rst || !stall_req)
	begin
		stall_len <= 0;
	end
	else
	begin
		stall_len <= stall_len + 1;
	end
end

a_store_has_ce: assert property (@(posedge clk) disable iff (rst) mem_mem_we |-> mem_mem_ce)
	else $error("store request without chip enable");

a_quiet_after_reset: assert property (@(posedge clk) rst |=> !(mem_reg_we || mem_hilo_we ||
	mem_cp0_we || mem_mem_ce || mem_mem_we || (|mem_except)))
	else $error("enable or exception bit high after reset");

a_stall_bounded: assert property (@(posedge clk) disable iff (rst) stall_len <= div_cycles + 2)
	else $error("stall_req held too long");

endmodule

bind cpu_ex_unit cpu_ex_unit_chk i_cpu_ex_unit_chk(
	.clk(clk),
	.rst(rst),
	.stall_req(stall_req),
	.mem_reg_we(mem_reg_we),
	.mem_hilo_we(mem_hilo_we),
	.mem_cp0_we(mem_cp0_we),
	.mem_mem_ce(mem_mem_ce),
	.mem_mem_we(mem_mem_we),
	.mem_except(mem_except)
);

/* hw/cpu_ex_unit.sv */
`timescale 1ns/10ps

module cpu_ex_unit(
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::bit_t         flush,
	input  cpu_pkg::oper_t        op,
	input  cpu_pkg::word_t        pc,
	input  cpu_pkg::word_t        inst,
	input  cpu_pkg::word_t        reg1,
	input  cpu_pkg::word_t        reg2,
	input  cpu_pkg::word_t        imm,
	input  cpu_pkg::bit_t         reg_we,
	input  cpu_pkg::reg_addr_t    reg_waddr,
	output cpu_pkg::bit_t         stall_req,
	output cpu_pkg::bit_t         mem_reg_we,
	output cpu_pkg::reg_addr_t    mem_reg_waddr,
	output cpu_pkg::word_t        mem_reg_wdata,
	output cpu_pkg::bit_t         mem_mem_ce,
	output cpu_pkg::bit_t         mem_mem_we,
	output cpu_pkg::word_t        mem_mem_addr,
	output logic [3:0]            mem_mem_sel,
	output cpu_pkg::word_t        mem_mem_wdata,
	output cpu_pkg::bit_t         mem_cp0_we,
	output cpu_pkg::reg_addr_t    mem_cp0_waddr,
	output cpu_pkg::cp0_sel_t     mem_cp0_sel,
	output cpu_pkg::word_t        mem_cp0_wdata,
	output cpu_pkg::bit_t         mem_hilo_we,
	output cpu_pkg::double_word_t mem_hilo,
	output cpu_pkg::except_t      mem_except
);

import cpu_pkg::*;

bit_t         ex_reg_we;
reg_addr_t    ex_reg_waddr;
word_t        ex_reg_wdata;
bit_t         ex_hilo_we;
double_word_t ex_hilo;
bit_t         ex_cp0_we;
reg_addr_t    ex_cp0_waddr;
cp0_sel_t     ex_cp0_sel;
word_t        ex_cp0_wdata;
bit_t         ex_mem_ce;
bit_t         ex_mem_we;
word_t        ex_mem_addr;
logic [3:0]   ex_mem_sel;
word_t        ex_mem_wdata;
except_t      ex_except;
double_word_t hilo;
reg_addr_t    cp0_raddr;
cp0_sel_t     cp0_rsel;
word_t        cp0_rdata;

cpu_ex i_cpu_ex(.*);

// latch output feeds forwarding and the committed state
ex_commit i_ex_commit(.*);

cp0_regs i_cp0_regs(.*);

endmodule

/* hw/cp0_regs.sv */
`timescale 1ns/10ps

module cp0_regs(
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::bit_t      mem_cp0_we,
	input  cpu_pkg::reg_addr_t mem_cp0_waddr,
	input  cpu_pkg::cp0_sel_t  mem_cp0_sel,
	input  cpu_pkg::word_t     mem_cp0_wdata,
	input  cpu_pkg::reg_addr_t cp0_raddr,
	input  cpu_pkg::cp0_sel_t  cp0_rsel,
	output cpu_pkg::word_t     cp0_rdata
);

import cpu_pkg::*;

word_t status;
word_t cause;
word_t epc;
word_t count;
word_t badvaddr;
word_t wmask;
bit_t  wr_hit;

assign wmask = cp0_write_mask(mem_cp0_waddr, mem_cp0_sel);
assign wr_hit = mem_cp0_we && (mem_cp0_sel == 3'd0);

always_ff @(posedge clk)
begin
	if (rst)
	begin
		status <= '0;
		cause <= '0;
		epc <= '0;
		count <= '0;
		badvaddr <= '0;
	end
	else
	begin
		// free running unless software writes it
		if (wr_hit && mem_cp0_waddr == cp0_count_addr)
		begin
			count <= (wmask & mem_cp0_wdata) | (~wmask & count);
		end
		else
		begin
			count <= count + 32'd1;
		end
		if (wr_hit)
		begin
			case (mem_cp0_waddr)
				cp0_status_addr: status <= (wmask & mem_cp0_wdata) | (~wmask & status);
				cp0_cause_addr: cause <= (wmask & mem_cp0_wdata) | (~wmask & cause);
				cp0_epc_addr: epc <= (wmask & mem_cp0_wdata) | (~wmask & epc);
				cp0_badvaddr_addr: badvaddr <= (wmask & mem_cp0_wdata) | (~wmask & badvaddr);
				default: status <= status;
			endcase
		end
	end
end

always_comb
begin
	cp0_rdata = '0;
	if (cp0_rsel == 3'd0)
	begin
		case (cp0_raddr)
			cp0_status_addr: cp0_rdata = status;
			cp0_cause_addr: cp0_rdata = cause;
			cp0_epc_addr: cp0_rdata = epc;
			cp0_count_addr: cp0_rdata = count;
			cp0_badvaddr_addr: cp0_rdata = badvaddr;
			default: cp0_rdata = '0;
		endcase
	end
end

endmodule

/* hw/ex_commit.sv */
`timescale 1ns/10ps

module ex_commit(
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::bit_t         flush,
	input  cpu_pkg::bit_t         stall_req,
	input  cpu_pkg::bit_t         ex_reg_we,
	input  cpu_pkg::reg_addr_t    ex_reg_waddr,
	input  cpu_pkg::word_t        ex_reg_wdata,
	input  cpu_pkg::bit_t         ex_hilo_we,
	input  cpu_pkg::double_word_t ex_hilo,
	input  cpu_pkg::bit_t         ex_cp0_we,
	input  cpu_pkg::reg_addr_t    ex_cp0_waddr,
	input  cpu_pkg::cp0_sel_t     ex_cp0_sel,
	input  cpu_pkg::word_t        ex_cp0_wdata,
	input  cpu_pkg::bit_t         ex_mem_ce,
	input  cpu_pkg::bit_t         ex_mem_we,
	input  cpu_pkg::word_t        ex_mem_addr,
	input  logic [3:0]            ex_mem_sel,
	input  cpu_pkg::word_t        ex_mem_wdata,
	input  cpu_pkg::except_t      ex_except,
	output cpu_pkg::bit_t         mem_reg_we,
	output cpu_pkg::reg_addr_t    mem_reg_waddr,
	output cpu_pkg::word_t        mem_reg_wdata,
	output cpu_pkg::bit_t         mem_hilo_we,
	output cpu_pkg::double_word_t mem_hilo,
	output cpu_pkg::bit_t         mem_cp0_we,
	output cpu_pkg::reg_addr_t    mem_cp0_waddr,
	output cpu_pkg::cp0_sel_t     mem_cp0_sel,
	output cpu_pkg::word_t        mem_cp0_wdata,
	output cpu_pkg::bit_t         mem_mem_ce,
	output cpu_pkg::bit_t         mem_mem_we,
	output cpu_pkg::word_t        mem_mem_addr,
	output logic [3:0]            mem_mem_sel,
	output cpu_pkg::word_t        mem_mem_wdata,
	output cpu_pkg::except_t      mem_except,
	output cpu_pkg::double_word_t hilo
);

// enables and exception bits
always_ff @(posedge clk)
begin
	if (rst || flush || stall_req)
	begin
		mem_reg_we <= 1'b0;
		mem_hilo_we <= 1'b0;
		mem_cp0_we <= 1'b0;
		mem_mem_ce <= 1'b0;
		mem_mem_we <= 1'b0;
		mem_except <= '0;
	end
	else
	begin
		mem_reg_we <= ex_reg_we;
		mem_hilo_we <= ex_hilo_we;
		mem_cp0_we <= ex_cp0_we;
		mem_mem_ce <= ex_mem_ce;
		mem_mem_we <= ex_mem_we;
		mem_except <= ex_except;
	end
end

always_ff @(posedge clk)
begin
	mem_reg_waddr <= ex_reg_waddr;
	mem_reg_wdata <= ex_reg_wdata;
	mem_hilo <= ex_hilo;
	mem_cp0_waddr <= ex_cp0_waddr;
	mem_cp0_sel <= ex_cp0_sel;
	mem_cp0_wdata <= ex_cp0_wdata;
	mem_mem_addr <= ex_mem_addr;
	mem_mem_sel <= ex_mem_sel;
	mem_mem_wdata <= ex_mem_wdata;
end

// committed hi/lo pair
always_ff @(posedge clk)
begin
	if (rst)
	begin
		hilo <= '0;
	end
	else if (mem_hilo_we)
	begin
		hilo <= mem_hilo;
	end
end

endmodule

/* hw/cpu_ex.sv */
`timescale 1ns/10ps

module cpu_ex(
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::bit_t         flush,
	input  cpu_pkg::oper_t        op,
	input  cpu_pkg::word_t        pc,
	input  cpu_pkg::word_t        inst,
	input  cpu_pkg::word_t        reg1,
	input  cpu_pkg::word_t        reg2,
	input  cpu_pkg::word_t        imm,
	input  cpu_pkg::bit_t         reg_we,
	input  cpu_pkg::reg_addr_t    reg_waddr,
	input  cpu_pkg::double_word_t hilo,
	input  cpu_pkg::bit_t         mem_hilo_we,
	input  cpu_pkg::double_word_t mem_hilo,
	input  cpu_pkg::bit_t         mem_cp0_we,
	input  cpu_pkg::reg_addr_t    mem_cp0_waddr,
	input  cpu_pkg::cp0_sel_t     mem_cp0_sel,
	input  cpu_pkg::word_t        mem_cp0_wdata,
	input  cpu_pkg::word_t        cp0_rdata,
	output cpu_pkg::reg_addr_t    cp0_raddr,
	output cpu_pkg::cp0_sel_t     cp0_rsel,
	output cpu_pkg::bit_t         stall_req,
	output cpu_pkg::bit_t         ex_reg_we,
	output cpu_pkg::reg_addr_t    ex_reg_waddr,
	output cpu_pkg::word_t        ex_reg_wdata,
	output cpu_pkg::bit_t         ex_hilo_we,
	output cpu_pkg::double_word_t ex_hilo,
	output cpu_pkg::bit_t         ex_cp0_we,
	output cpu_pkg::reg_addr_t    ex_cp0_waddr,
	output cpu_pkg::cp0_sel_t     ex_cp0_sel,
	output cpu_pkg::word_t        ex_cp0_wdata,
	output cpu_pkg::bit_t         ex_mem_ce,
	output cpu_pkg::bit_t         ex_mem_we,
	output cpu_pkg::word_t        ex_mem_addr,
	output logic [3:0]            ex_mem_sel,
	output cpu_pkg::word_t        ex_mem_wdata,
	output cpu_pkg::except_t      ex_except
);

import cpu_pkg::*;

double_word_t hilo_fwd;
word_t        hi;
word_t        lo;
word_t        cp0_wmask;
word_t        cp0_fwd;
word_t        add_res;
word_t        sub_res;
bit_t         signed_lt;
bit_t         unsigned_lt;
bit_t         ov_add;
bit_t         ov_sub;
word_t        clz_cnt;
word_t        clo_cnt;
word_t        mem_addr;
bit_t         is_load;
bit_t         is_store;
double_word_t multi_ret;
word_t        mult_word;

// pending write in the latch is newer than the committed pair
assign hilo_fwd = mem_hilo_we ? mem_hilo : hilo;
assign hi = hilo_fwd[63:32];
assign lo = hilo_fwd[31:0];

assign cp0_raddr = inst[15:11];
assign cp0_rsel = inst[2:0];
assign cp0_wmask = cp0_write_mask(cp0_raddr, cp0_rsel);
assign cp0_fwd = (mem_cp0_we && mem_cp0_waddr == cp0_raddr && mem_cp0_sel == cp0_rsel)
	? ((cp0_wmask & mem_cp0_wdata) | (~cp0_wmask & cp0_rdata)) : cp0_rdata;

assign add_res = reg1 + reg2;
assign sub_res = reg1 - reg2;
assign signed_lt = (reg1[31] != reg2[31]) ? reg1[31] : sub_res[31];
assign unsigned_lt = (reg1 < reg2);
assign ov_add = (reg1[31] == reg2[31]) & (reg1[31] ^ add_res[31]);
assign ov_sub = (reg1[31] ^ reg2[31]) & (reg1[31] ^ sub_res[31]);

ex_count_bit i_count_clz(
	.bit_val(1'b0),
	.val(reg1),
	.count(clz_cnt)
);

ex_count_bit i_count_clo(
	.bit_val(1'b1),
	.val(reg1),
	.count(clo_cnt)
);

ex_multi_cyc i_multi_cyc(
	.clk,
	.rst,
	.flush,
	.op,
	.reg1,
	.reg2,
	.ret(multi_ret),
	.mult_word,
	.is_busy(stall_req)
);

assign ex_reg_we = reg_we;
assign ex_reg_waddr = reg_waddr;

always_comb
begin
	case (op)
		op_lui: ex_reg_wdata = {imm[15:0], 16'b0};
		op_and: ex_reg_wdata = reg1 & reg2;
		op_or: ex_reg_wdata = reg1 | reg2;
		op_xor: ex_reg_wdata = reg1 ^ reg2;
		op_nor: ex_reg_wdata = ~(reg1 | reg2);
		op_add, op_addu: ex_reg_wdata = add_res;
		op_sub, op_subu: ex_reg_wdata = sub_res;
		op_slt: ex_reg_wdata = {31'b0, signed_lt};
		op_sltu: ex_reg_wdata = {31'b0, unsigned_lt};
		op_sll: ex_reg_wdata = reg2 << inst[10:6];
		op_srl: ex_reg_wdata = reg2 >> inst[10:6];
		op_sra: ex_reg_wdata = $signed(reg2) >>> inst[10:6];
		op_sllv: ex_reg_wdata = reg2 << reg1[4:0];
		op_srlv: ex_reg_wdata = reg2 >> reg1[4:0];
		op_srav: ex_reg_wdata = $signed(reg2) >>> reg1[4:0];
		op_clz: ex_reg_wdata = clz_cnt;
		op_clo: ex_reg_wdata = clo_cnt;
		op_jal, op_jalr: ex_reg_wdata = pc + 32'd8;
		op_mfhi: ex_reg_wdata = hi;
		op_mflo: ex_reg_wdata = lo;
		op_mul: ex_reg_wdata = mult_word;
		op_mfc0: ex_reg_wdata = cp0_fwd;
		default: ex_reg_wdata = '0;
	endcase
end

assign ex_hilo_we = op inside {op_mthi, op_mtlo, op_mult, op_multu, op_div, op_divu};

always_comb
begin
	case (op)
		op_mthi: ex_hilo = {reg1, lo};
		op_mtlo: ex_hilo = {hi, reg1};
		op_mult, op_multu, op_div, op_divu: ex_hilo = multi_ret;
		default: ex_hilo = hilo_fwd;
	endcase
end

assign ex_cp0_we = (op == op_mtc0);
assign ex_cp0_waddr = inst[15:11];
assign ex_cp0_sel = inst[2:0];
assign ex_cp0_wdata = reg2;

assign mem_addr = reg1 + imm;
assign is_load = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
assign is_store = op inside {op_sb, op_sh, op_sw};
assign ex_mem_ce = is_load | is_store;
assign ex_mem_we = is_store;
assign ex_mem_addr = mem_addr;

always_comb
begin
	case (op)
		op_lw, op_sw:
		begin
			ex_mem_sel = 4'b1111;
			ex_mem_wdata = reg2;
		end
		op_lh, op_lhu, op_sh:
		begin
			ex_mem_sel = mem_addr[1] ? 4'b1100 : 4'b0011;
			ex_mem_wdata = mem_addr[1] ? (reg2 << 16) : reg2;
		end
		op_lb, op_lbu, op_sb:
		begin
			ex_mem_sel = 4'b0001 << mem_addr[1:0];
			ex_mem_wdata = reg2 << {mem_addr[1:0], 3'b000};
		end
		default:
		begin
			ex_mem_sel = 4'b0000;
			ex_mem_wdata = '0;
		end
	endcase
end

assign ex_except[except_overflow] = ((op == op_add) & ov_add) | ((op == op_sub) & ov_sub);
assign ex_except[except_daddr_unaligned] =
	((op inside {op_lw, op_sw}) & (mem_addr[1] | mem_addr[0])) |
	((op inside {op_lh, op_lhu, op_sh}) & mem_addr[0]);
assign ex_except[except_syscall] = (op == op_syscall);
assign ex_except[except_break] = (op == op_break);
assign ex_except[except_eret] = (op == op_eret);
assign ex_except[except_invalid_inst] = (op == op_invalid);
assign ex_except[except_priv_inst] = op inside {op_mfc0, op_mtc0, op_eret};

endmodule

/* hw/ex_multi_cyc.sv */
`timescale 1ns/10ps

module ex_multi_cyc(
	input  logic                  clk,
	input  logic                  rst,
	input  cpu_pkg::bit_t         flush,
	input  cpu_pkg::oper_t        op,
	input  cpu_pkg::word_t        reg1,
	input  cpu_pkg::word_t        reg2,
	output cpu_pkg::double_word_t ret,
	output cpu_pkg::word_t        mult_word,
	output cpu_pkg::bit_t         is_busy
);

import cpu_pkg::*;

typedef enum logic [1:0] {
	s_idle,
	s_div,
	s_done
} state_t;

state_t       state;
logic [5:0]   div_cnt;
bit_t         res_is_div;
bit_t         is_mul_op;
bit_t         is_div_op;
bit_t         mul_signed;
bit_t         div_signed;
double_word_t mul_a;
double_word_t mul_b;
double_word_t mul_res;
word_t        div_rem;
word_t        div_quo;
word_t        div_dvs;
bit_t         neg_q;
bit_t         neg_r;
logic [32:0]  trial;
word_t        quo_fix;
word_t        rem_fix;

assign is_mul_op = (op == op_mult) || (op == op_multu) || (op == op_mul);
assign is_div_op = (op == op_div) || (op == op_divu);
assign mul_signed = (op != op_multu);
assign div_signed = (op == op_div);

// sign extend to 64 bits, low half of the product is exact
assign mul_a = mul_signed ? {{32{reg1[31]}}, reg1} : {32'b0, reg1};
assign mul_b = mul_signed ? {{32{reg2[31]}}, reg2} : {32'b0, reg2};

// one restoring step
assign trial = {div_rem, div_quo[31]} - {1'b0, div_dvs};
assign quo_fix = neg_q ? -div_quo : div_quo;
assign rem_fix = neg_r ? -div_rem : div_rem;

assign ret = res_is_div ? {rem_fix, quo_fix} : mul_res;
assign mult_word = mul_res[31:0];
assign is_busy = (state == s_div) || ((state == s_idle) && (is_mul_op || is_div_op));

always_ff @(posedge clk)
begin
	if (rst)
	begin
		state <= s_idle;
		div_cnt <= '0;
		res_is_div <= 1'b0;
	end
	else if (flush)
	begin
		state <= s_idle;
		div_cnt <= '0;
	end
	else
	begin
		case (state)
			s_idle:
			begin
				div_cnt <= '0;
				if (is_mul_op)
				begin
					state <= s_done;
					res_is_div <= 1'b0;
				end
				else if (is_div_op)
				begin
					state <= s_div;
					res_is_div <= 1'b1;
				end
			end
			s_div:
			begin
				div_cnt <= div_cnt + 6'd1;
				if (div_cnt == 6'(div_cycles - 1))
				begin
					state <= s_done;
				end
			end
			// held instruction is skipped here so it does not restart
			default: state <= s_idle;
		endcase
	end
end

always_ff @(posedge clk)
begin
	if (state == s_idle)
	begin
		mul_res <= mul_a * mul_b;
		div_quo <= (div_signed && reg1[31]) ? -reg1 : reg1;
		div_dvs <= (div_signed && reg2[31]) ? -reg2 : reg2;
		div_rem <= '0;
		// divide by zero keeps the all ones quotient
		neg_q <= div_signed && (reg1[31] ^ reg2[31]) && (reg2 != '0);
		neg_r <= div_signed && reg1[31];
	end
	else if (state == s_div)
	begin
		if (!trial[32])
		begin
			div_rem <= trial[31:0];
			div_quo <= {div_quo[30:0], 1'b1};
		end
		else
		begin
			div_rem <= {div_rem[30:0], div_quo[31]};
			div_quo <= {div_quo[30:0], 1'b0};
		end
	end
end

endmodule

/* hw/ex_count_bit.sv */
`timescale 1ns/10ps

module ex_count_bit(
	input  cpu_pkg::bit_t  bit_val,
	input  cpu_pkg::word_t val,
	output cpu_pkg::word_t count
);

import cpu_pkg::*;

// scan upward so the highest differing bit decides
always_comb
begin
	count = word_t'(32);
	for (int i = 0; i < 32; i++)
	begin
		if (val[i] != bit_val)
		begin
			count = word_t'(31 - i);
		end
	end
end

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

typedef logic        bit_t;
typedef logic [31:0] word_t;
typedef logic [63:0] double_word_t;
typedef logic [4:0]  reg_addr_t;
typedef logic [2:0]  cp0_sel_t;

typedef enum logic [5:0] {
	op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
	op_and, op_or, op_xor, op_nor, op_lui,
	op_add, op_addu, op_sub, op_subu, op_slt, op_sltu,
	op_clz, op_clo, op_jal, op_jalr,
	op_mfhi, op_mflo, op_mthi, op_mtlo,
	op_mult, op_multu, op_div, op_divu, op_mul,
	op_mfc0, op_mtc0,
	op_lb, op_lbu, op_lh, op_lhu, op_lw, op_sb, op_sh, op_sw,
	op_syscall, op_break, op_eret,
	op_invalid
} oper_t;

// cp0 register numbers, all at select 0
localparam reg_addr_t cp0_badvaddr_addr = 5'd8;
localparam reg_addr_t cp0_count_addr    = 5'd9;
localparam reg_addr_t cp0_status_addr   = 5'd12;
localparam reg_addr_t cp0_cause_addr    = 5'd13;
localparam reg_addr_t cp0_epc_addr      = 5'd14;

localparam int div_cycles = 32;

// bit positions in the exception vector
localparam int except_overflow        = 0;
localparam int except_daddr_unaligned = 1;
localparam int except_syscall         = 2;
localparam int except_break           = 3;
localparam int except_eret            = 4;
localparam int except_invalid_inst    = 5;
localparam int except_priv_inst       = 6;
localparam int except_w               = 7;

typedef logic [except_w-1:0] except_t;

function automatic word_t cp0_write_mask(input reg_addr_t addr, input cp0_sel_t sel);
	word_t mask;
	mask = '0;
	if (sel == 3'd0)
	begin
		case (addr)
			// im field plus exl and ie
			cp0_status_addr: mask = 32'h0000_ff03;
			// software interrupt bits
			cp0_cause_addr: mask = 32'h0000_0300;
			cp0_epc_addr, cp0_count_addr: mask = '1;
			default: mask = '0;
		endcase
	end
	return mask;
endfunction

endpackage
